// ==== hdl/df_pkg.sv ====
`default_nettype none

package df_pkg;

    // Token packet field widths
    localparam int GEN_W  = 11;
    localparam int DEST_W = 7;
    localparam int CTRL_W = 2;
    localparam int DATA_W = 16;

    // Instruction word field widths
    localparam int FLAG_W = 4;
    localparam int OPC_W  = 6;
    localparam int PS_W   = DEST_W + FLAG_W + OPC_W;

    // Flag bit positions
    // Bits 2 and 3 are stored in the word and never decoded
    localparam int FLAG_SWAP   = 0;
    localparam int FLAG_ZERO_B = 1;

    // One store entry per destination address
    localparam int PS_DEPTH = 128;

    // Configuration port widths
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    // Deleted token counter width
    localparam int CNT_W = 16;

    // Opcodes of the function stage
    // Unlisted codes fall through to ADD
    typedef enum logic [OPC_W-1:0] {
        ADD    = 6'd0,
        SUB    = 6'd1,
        MUL    = 6'd2,
        BZ     = 6'd3,
        ABSORB = 6'd63
    } opcode_e;

    // Program store word, next destination in the top bits
    typedef struct packed {
        logic [DEST_W-1:0] next_dest;
        logic [FLAG_W-1:0] flags;
        opcode_e           opcode;
    } ps_word_t;

    // Token as it travels on the ring
    typedef struct packed {
        logic [GEN_W-1:0]  gen;
        logic [DEST_W-1:0] dest;
        logic [CTRL_W-1:0] ctrl;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } token_t;

    // Token after the store stage, dest replaced by the fetched word
    typedef struct packed {
        logic [GEN_W-1:0]  gen;
        ps_word_t          instr;
        logic [CTRL_W-1:0] ctrl;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } merged_t;

endpackage

`default_nettype wire

// ==== hdl/df_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     CP,
    input  logic     MR,
    input  logic     in_send,
    input  payload_t in_data,
    output logic     in_ack,
    output logic     out_send,
    output payload_t out_data,
    input  logic     out_ack,
    output logic     load
);

    logic full;

    // Room when empty, or when the held token leaves this cycle
    assign in_ack = !full || out_ack;

    // Accepting cycle, also used by neighbours for side data
    assign load = in_send && in_ack;

    assign out_send = full;

    // Occupancy flag
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out_ack) begin
            // Drained without a replacement
            full <= 1'b0;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge CP) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/df_program_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_program_store (
    input  logic                          CP,
    input  logic                          MR,
    // APB configuration port
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [df_pkg::APB_AW-1:0]     paddr,
    input  logic [df_pkg::APB_DW-1:0]     pwdata,
    output logic [df_pkg::APB_DW-1:0]     prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Token fetch port
    input  logic                          fetch_en,
    input  logic [df_pkg::DEST_W-1:0]     fetch_addr,
    output df_pkg::ps_word_t              fetch_word
);

    df_pkg::ps_word_t mem [df_pkg::PS_DEPTH];

    logic [df_pkg::DEST_W-1:0] word_idx;
    logic                      addr_bad;
    logic                      access;
    logic                      wr_en;

    // Word aligned index, byte lane bits dropped
    assign word_idx = paddr[df_pkg::DEST_W+1:2];

    // Anything above the store window is an error
    assign addr_bad = |paddr[df_pkg::APB_AW-1:df_pkg::DEST_W+2];

    // Access phase of a transfer
    assign access = psel && penable;
    assign wr_en  = access && pwrite && !addr_bad;

    // No wait states
    assign pready = 1'b1;

    assign pslverr = access && addr_bad;

    // Read data zero extended, forced to zero on a bad address
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && !addr_bad) begin
            prdata = {{(df_pkg::APB_DW - df_pkg::PS_W){1'b0}}, mem[word_idx]};
        end
    end

    // Store array
    // Cleared on reset so an unloaded entry decodes as ADD to 0
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            for (int i = 0; i < df_pkg::PS_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word_idx] <= df_pkg::ps_word_t'(pwdata[df_pkg::PS_W-1:0]);
        end
    end

    // Fetch register
    // A write to the same entry on this edge is not seen until later
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            fetch_word <= '0;
        end else if (fetch_en) begin
            fetch_word <= mem[fetch_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/df_ps_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_ps_stage (
    input  logic                      CP,
    input  logic                      MR,
    // Incoming tokens
    input  logic                      in_send,
    input  df_pkg::token_t            in_tok,
    output logic                      in_ack,
    // Merged tokens to the function stage
    output logic                      out_send,
    output df_pkg::merged_t           out_tok,
    input  logic                      out_ack,
    // Number of ABSORB deletions, wraps
    output logic [df_pkg::CNT_W-1:0]  del_count,
    // APB to the program store
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [df_pkg::APB_AW-1:0] paddr,
    input  logic [df_pkg::APB_DW-1:0] pwdata,
    output logic [df_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);

    df_pkg::token_t   tok_q;
    df_pkg::ps_word_t word;
    logic             reg_send;
    logic             reg_ack;
    logic             load;
    logic             absorb;

    // Deleted tokens leave the register without a downstream ack
    assign reg_ack = out_ack || absorb;

    df_stage_reg #(
        .payload_t (df_pkg::token_t)
    ) u_reg (
        .CP       (CP),
        .MR       (MR),
        .in_send  (in_send),
        .in_data  (in_tok),
        .in_ack   (in_ack),
        .out_send (reg_send),
        .out_data (tok_q),
        .out_ack  (reg_ack),
        .load     (load)
    );

    // Fetch on the accepting edge using the live dest field
    df_program_store u_store (
        .CP         (CP),
        .MR         (MR),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fetch_en   (load),
        .fetch_addr (in_tok.dest),
        .fetch_word (word)
    );

    assign absorb = (word.opcode == df_pkg::ABSORB);

    // Merge, dest replaced by the instruction word
    assign out_tok.gen   = tok_q.gen;
    assign out_tok.instr = word;
    assign out_tok.ctrl  = tok_q.ctrl;
    assign out_tok.a     = tok_q.a;
    assign out_tok.b     = tok_q.b;

    // ABSORB tokens are never offered downstream
    assign out_send = reg_send && !absorb;

    // One count per deleted token, it drains in the same cycle
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            del_count <= '0;
        end else if (reg_send && absorb) begin
            del_count <= del_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/df_func_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_func_stage (
    input  logic            CP,
    input  logic            MR,
    // Merged tokens from the store stage
    input  logic            in_send,
    input  df_pkg::merged_t in_tok,
    output logic            in_ack,
    // Result tokens
    output logic            out_send,
    output df_pkg::token_t  out_tok,
    input  logic            out_ack
);

    logic [df_pkg::DATA_W-1:0] op_a;
    logic [df_pkg::DATA_W-1:0] op_b;
    logic [df_pkg::DATA_W-1:0] alu;
    logic [df_pkg::DEST_W-1:0] next;
    df_pkg::token_t            res;

    // Operand conditioning, swap before zeroing b
    always_comb begin
        op_a = in_tok.a;
        op_b = in_tok.b;
        if (in_tok.instr.flags[df_pkg::FLAG_SWAP]) begin
            op_a = in_tok.b;
            op_b = in_tok.a;
        end
        if (in_tok.instr.flags[df_pkg::FLAG_ZERO_B]) begin
            op_b = '0;
        end
    end

    // Execute and route
    always_comb begin
        next = in_tok.instr.next_dest;
        case (in_tok.instr.opcode)
            df_pkg::SUB: begin
                alu = op_a - op_b;
            end
            df_pkg::MUL: begin
                // Low half of the product only
                alu = op_a * op_b;
            end
            df_pkg::BZ: begin
                alu = op_a;
                // Branch when nonzero, wraps at the top of the store
                if (op_a != '0) begin
                    next = in_tok.instr.next_dest + 1'b1;
                end
            end
            default: begin
                alu = op_a + op_b;
            end
        endcase
    end

    // Result token
    assign res.gen  = in_tok.gen;
    assign res.dest = next;
    assign res.ctrl = in_tok.ctrl;
    assign res.a    = alu;
    assign res.b    = op_b;

    df_stage_reg #(
        .payload_t (df_pkg::token_t)
    ) u_reg (
        .CP       (CP),
        .MR       (MR),
        .in_send  (in_send),
        .in_data  (res),
        .in_ack   (in_ack),
        .out_send (out_send),
        .out_data (out_tok),
        .out_ack  (out_ack),
        .load     ()
    );

endmodule

`default_nettype wire

// ==== hdl/df_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_pipe_top (
    input  logic                      CP,
    input  logic                      MR,
    // APB configuration port
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [df_pkg::APB_AW-1:0] paddr,
    input  logic [df_pkg::APB_DW-1:0] pwdata,
    output logic [df_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Token input
    input  logic                      in_send,
    input  df_pkg::token_t            in_tok,
    output logic                      in_ack,
    // Result output
    output logic                      out_send,
    output df_pkg::token_t            out_tok,
    input  logic                      out_ack,
    // ABSORB deletions
    output logic [df_pkg::CNT_W-1:0]  del_count
);

    // Link between the two stages
    logic            mid_send;
    logic            mid_ack;
    df_pkg::merged_t mid_tok;

    df_ps_stage u_ps (
        .CP        (CP),
        .MR        (MR),
        .in_send   (in_send),
        .in_tok    (in_tok),
        .in_ack    (in_ack),
        .out_send  (mid_send),
        .out_tok   (mid_tok),
        .out_ack   (mid_ack),
        .del_count (del_count),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    df_func_stage u_func (
        .CP       (CP),
        .MR       (MR),
        .in_send  (mid_send),
        .in_tok   (mid_tok),
        .in_ack   (mid_ack),
        .out_send (out_send),
        .out_tok  (out_tok),
        .out_ack  (out_ack)
    );

endmodule

`default_nettype wire

// ==== bench/df_pipe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_pipe_checker (
    input  logic                      CP,
    input  logic                      MR,
    input  int                        cycle,
    // APB responses
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [df_pkg::APB_DW-1:0] prdata,
    input  logic                      pready,
    input  logic                      pslverr,
    // Token handshakes
    input  logic                      in_send,
    input  logic                      in_ack,
    input  logic                      out_send,
    input  df_pkg::token_t            out_tok,
    input  logic                      out_ack,
    input  logic [df_pkg::CNT_W-1:0]  del_count
);

    // Expected results in arrival order
    df_pkg::token_t            exp_tok [$];
    int                        exp_cyc [$];
    logic [df_pkg::APB_DW-1:0] exp_data [$];
    logic                      exp_err [$];

    // Entry under comparison
    df_pkg::token_t            want_tok;
    int                        want_cyc;
    logic [df_pkg::APB_DW-1:0] want_data;
    logic                      want_err;

    // Exact latency and no input stall while streaming
    logic strict = 1'b0;

    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests = 0;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("error at time %0t: %s expected %0h got %0h", $time, name, exp, got);
        errors++;
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("at time %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare(input string name, input logic [63:0] exp,
                           input logic [63:0] got);
        checks++;
        if (exp !== got) begin
            report_mismatch(name, exp, got);
        end
    endtask

    // Stamp is the cycle of the input transfer
    task automatic push_token(input df_pkg::token_t tok, input int stamp);
        exp_tok.push_back(tok);
        exp_cyc.push_back(stamp);
    endtask

    // Read data is ignored for writes
    task automatic push_apb(input logic [df_pkg::APB_DW-1:0] data, input logic err);
        exp_data.push_back(data);
        exp_err.push_back(err);
    endtask

    task automatic set_strict(input logic on);
        strict = on;
    endtask

    function automatic int pending();
        return exp_tok.size();
    endfunction

    function automatic int error_total();
        return errors;
    endfunction

    // State right after reset
    task automatic check_idle();
        compare("out_send", 1'b0, out_send);
        compare("pslverr", 1'b0, pslverr);
        compare("in_ack", 1'b1, in_ack);
        compare("del_count", '0, del_count);
    endtask

    task automatic check_count(input logic [df_pkg::CNT_W-1:0] exp);
        compare("del_count", exp, del_count);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    task automatic report();
        if (exp_tok.size() != 0) begin
            report_problem("expected result tokens never came out");
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

    always @(posedge CP) begin
        if (!MR) begin
            // Access phase ends on this edge
            if (psel && penable) begin
                if (exp_err.size() == 0) begin
                    report_problem("APB access with no expected response");
                end else begin
                    want_data = exp_data.pop_front();
                    want_err  = exp_err.pop_front();
                    compare("pready", 1'b1, pready);
                    compare("pslverr", want_err, pslverr);
                    if (!pwrite) begin
                        compare("prdata", want_data, prdata);
                    end
                end
            end
            if (strict && in_send && !in_ack) begin
                report_problem("in_ack dropped during a stream with out_ack held high");
            end
            // Result transfer
            if (out_send && out_ack) begin
                if (exp_tok.size() == 0) begin
                    report_problem("result token arrived with none expected");
                end else begin
                    want_tok = exp_tok.pop_front();
                    want_cyc = exp_cyc.pop_front();
                    compare("out_tok", want_tok, out_tok);
                    if (strict) begin
                        compare("latency", 2, cycle - want_cyc);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/df_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module df_pipe_tb;

    localparam int unsigned SEED = 32'hc03a267e;

    // Test sizes
    localparam int N_RW     = 16;
    localparam int N_TOK    = 64;
    localparam int N_BZ     = 8;
    localparam int N_ABS    = 24;
    localparam int N_STREAM = 32;
    localparam int N_BP     = 96;

    // Three cycles per APB access, five drains
    localparam int N_APB       = 2 * N_RW + 3 + df_pkg::PS_DEPTH + 7;
    localparam int N_SENT      = N_TOK + N_BZ + N_ABS + N_STREAM + N_BP;
    localparam int STIM_CYCLES = 10 + 3 * N_APB + N_SENT + 5 * 8;
    localparam int TIMEOUT     = 4 * STIM_CYCLES + 200;

    logic                      CP = 1'b0;
    logic                      MR;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [df_pkg::APB_AW-1:0] paddr;
    logic [df_pkg::APB_DW-1:0] pwdata;
    logic [df_pkg::APB_DW-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      in_send;
    df_pkg::token_t            in_tok;
    logic                      in_ack;
    logic                      out_send;
    df_pkg::token_t            out_tok;
    logic                      out_ack;
    logic [df_pkg::CNT_W-1:0]  del_count;

    // Copy of the store as written over APB
    df_pkg::ps_word_t mirror [df_pkg::PS_DEPTH];

    int   cycles  = 0;
    int   del_exp = 0;
    logic bp_on   = 1'b0;

    df_pipe_top DUT (
        .CP        (CP),
        .MR        (MR),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_send   (in_send),
        .in_tok    (in_tok),
        .in_ack    (in_ack),
        .out_send  (out_send),
        .out_tok   (out_tok),
        .out_ack   (out_ack),
        .del_count (del_count)
    );

    df_pipe_checker u_check (
        .CP        (CP),
        .MR        (MR),
        .cycle     (cycles),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_send   (in_send),
        .in_ack    (in_ack),
        .out_send  (out_send),
        .out_tok   (out_tok),
        .out_ack   (out_ack),
        .del_count (del_count)
    );

    always #10 CP = ~CP;

    always @(posedge CP) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= TIMEOUT);
        $display("run stopped: no progress after %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
    end

    // Result sink ready two cycles in three under back-pressure
    always @(negedge CP) begin
        if (bp_on) begin
            out_ack = ($urandom % 3) != 0;
        end else begin
            out_ack = 1'b1;
        end
    end

    // Expected result of one token, returns 1 when it is deleted
    function automatic logic predict(input df_pkg::token_t t, output df_pkg::token_t r);
        df_pkg::ps_word_t          w;
        logic [df_pkg::DATA_W-1:0] x;
        logic [df_pkg::DATA_W-1:0] y;
        w = mirror[t.dest];
        r = t;
        // Swap first, then zero b
        x = w.flags[0] ? t.b : t.a;
        y = w.flags[0] ? t.a : t.b;
        if (w.flags[1]) begin
            y = '0;
        end
        r.dest = w.next_dest;
        r.b    = y;
        case (w.opcode)
            df_pkg::SUB: begin
                r.a = x - y;
            end
            df_pkg::MUL: begin
                r.a = x * y;
            end
            df_pkg::BZ: begin
                r.a = x;
                if (x != '0) begin
                    r.dest = w.next_dest + 7'd1;
                end
            end
            default: begin
                r.a = x + y;
            end
        endcase
        return w.opcode == df_pkg::ABSORB;
    endfunction

    // ADD, SUB, MUL or an unlisted code, all flags random
    function automatic df_pkg::ps_word_t rand_word();
        df_pkg::ps_word_t w;
        int               pick;
        pick        = $urandom % 4;
        w.next_dest = 7'($urandom);
        w.flags     = 4'($urandom);
        if (pick == 3) begin
            w.opcode = df_pkg::opcode_e'(6'(4 + $urandom % 59));
        end else begin
            w.opcode = df_pkg::opcode_e'(6'(pick));
        end
        return w;
    endfunction

    function automatic df_pkg::token_t rand_token(input logic [df_pkg::DEST_W-1:0] dest);
        df_pkg::token_t t;
        t.gen  = 11'($urandom);
        t.dest = dest;
        t.ctrl = 2'($urandom);
        t.a    = 16'($urandom);
        t.b    = 16'($urandom);
        return t;
    endfunction

    // Setup, access, then one idle cycle
    task automatic apb_access(input logic wr, input logic [df_pkg::APB_AW-1:0] addr,
                              input logic [df_pkg::APB_DW-1:0] data);
        @(negedge CP);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge CP);
        penable = 1'b1;
        @(negedge CP);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic store_word(input logic [df_pkg::DEST_W-1:0] idx, input df_pkg::ps_word_t w);
        u_check.push_apb('0, 1'b0);
        apb_access(1'b1, {3'b000, idx, 2'b00}, {15'b0, w});
        mirror[idx] = w;
    endtask

    task automatic read_word(input logic [df_pkg::DEST_W-1:0] idx);
        u_check.push_apb({15'b0, mirror[idx]}, 1'b0);
        apb_access(1'b0, {3'b000, idx, 2'b00}, '0);
    endtask

    // Offer a token until it is taken, then record what should come out
    task automatic send_token(input df_pkg::token_t t);
        df_pkg::token_t r;
        @(negedge CP);
        in_send = 1'b1;
        in_tok  = t;
        @(posedge CP);
        while (!in_ack) begin
            @(posedge CP);
        end
        if (predict(t, r)) begin
            del_exp++;
        end else begin
            u_check.push_token(r, cycles);
        end
    endtask

    task automatic idle_cycle();
        @(negedge CP);
        in_send = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (u_check.pending() != 0) begin
            @(negedge CP);
        end
        // Deleted tokens leave the store stage a little later
        repeat (4) @(negedge CP);
    endtask

    initial begin
        df_pkg::token_t            t;
        df_pkg::ps_word_t          w;
        logic [df_pkg::DEST_W-1:0] idx;
        logic [df_pkg::DEST_W-1:0] written [$];
        void'($urandom(SEED));
        MR      = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        in_send = 1'b0;
        in_tok  = '0;
        out_ack = 1'b1;
        for (int i = 0; i < df_pkg::PS_DEPTH; i++) begin
            mirror[i] = '0;
        end
        repeat (10) @(negedge CP);
        MR = 1'b0;
        u_check.check_idle();

        // Random writes, then read every one back
        for (int i = 0; i < N_RW; i++) begin
            idx = 7'($urandom);
            written.push_back(idx);
            store_word(idx, rand_word());
        end
        foreach (written[i]) begin
            read_word(written[i]);
        end
        // Out of window, aliasing the first entry
        idx = written[0];
        u_check.push_apb('0, 1'b1);
        apb_access(1'b1, {3'b001, idx, 2'b00}, 32'h1ffff);
        u_check.push_apb('0, 1'b1);
        apb_access(1'b0, {3'b111, idx, 2'b00}, '0);
        read_word(idx);
        u_check.end_test("apb readback");

        // Whole store gets arithmetic words
        for (int i = 0; i < df_pkg::PS_DEPTH; i++) begin
            store_word(7'(i), rand_word());
        end
        for (int i = 0; i < N_TOK; i++) begin
            send_token(rand_token(7'($urandom)));
        end
        drain();
        u_check.end_test("alu ops");

        // Branch entries, the second one wraps past 127
        w           = '0;
        w.opcode    = df_pkg::BZ;
        w.next_dest = 7'd20;
        store_word(7'd10, w);
        w.next_dest = 7'd127;
        store_word(7'd11, w);
        for (int i = 0; i < N_BZ; i++) begin
            t = rand_token(7'd10 + 7'(i % 2));
            if ((i % 4) < 2) begin
                t.a = '0;
            end else begin
                t.a = t.a | 16'h1;
            end
            send_token(t);
        end
        drain();
        u_check.end_test("bz routing");

        // Four deleting entries and one plain ADD
        for (int i = 30; i < 34; i++) begin
            w        = rand_word();
            w.opcode = df_pkg::ABSORB;
            store_word(7'(i), w);
        end
        store_word(7'd34, '0);
        for (int i = 0; i < N_ABS; i++) begin
            send_token(rand_token(7'(30 + $urandom % 5)));
        end
        drain();
        u_check.check_count(16'(del_exp));
        u_check.end_test("absorb");

        // Back to back stream, sink always ready
        u_check.set_strict(1'b1);
        for (int i = 0; i < N_STREAM; i++) begin
            send_token(rand_token(7'(40 + $urandom % 80)));
        end
        drain();
        u_check.set_strict(1'b0);
        u_check.end_test("stream latency");

        // Random sink stalls and input gaps over the whole program
        bp_on <= 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            if (($urandom % 4) == 0) begin
                idle_cycle();
            end
            send_token(rand_token(7'($urandom)));
        end
        drain();
        bp_on <= 1'b0;
        u_check.check_count(16'(del_exp));
        u_check.end_test("back-pressure");

        u_check.report();
        if (u_check.error_total() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/df_pkg.sv
hdl/df_stage_reg.sv
hdl/df_program_store.sv
hdl/df_ps_stage.sv
hdl/df_func_stage.sv
hdl/df_pipe_top.sv
bench/df_pipe_checker.sv
bench/df_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: df_pipe

sources:
  - hdl/df_pkg.sv
  - hdl/df_stage_reg.sv
  - hdl/df_program_store.sv
  - hdl/df_ps_stage.sv
  - hdl/df_func_stage.sv
  - hdl/df_pipe_top.sv
  - target: simulation
    files:
      - bench/df_pipe_checker.sv
      - bench/df_pipe_tb.sv
